//--- design/bcdAddPkg.sv
`default_nettype none

package bcdAddPkg;

    ////////////////////
    // Command codes
    ////////////////////

    // One code per datapath action
    // Values match the request and acknowledge bit order in the datapath
    typedef enum logic [2:0]
    {
        CmdInit   = 3'd0,
        CmdLoadA  = 3'd1,
        CmdLoadB  = 3'd2,
        CmdShowA  = 3'd3,
        CmdShowB  = 3'd4,
        CmdAdd    = 3'd5,
        CmdShowLs = 3'd6,
        CmdShowMs = 3'd7
    } cmdCodeT;

    ////////////////////
    // Digit type
    ////////////////////

    // One decimal digit, 0 to 9 in normal use
    typedef logic [3:0] bcdDigitT;

    ////////////////////
    // Shared limits
    ////////////////////

    // Default operand width, enough for 0 to 99
    localparam int OperandWidth = 7;

    // Largest operand a load accepts
    localparam int OperandMax = 99;

    // 99 + 99 = 198, so three digits
    localparam int SumDigits = 3;

endpackage

`default_nettype wire

//--- design/binToBcd.sv
`timescale 1ns/1ps
`default_nettype none

// Binary to packed BCD, double dabble
// Pure combinational, no clock
module binToBcd #(
    parameter int InWidth = 7,
    parameter int Digits  = 2
) (
    input  wire logic [InWidth-1:0]                bin,
    output bcdAddPkg::bcdDigitT [Digits-1:0]       digits
);

    // Scratch digits, shifted one input bit at a time
    logic [Digits*4-1:0] bcdWork;

    ////////////////////
    // Shift and add 3
    ////////////////////

    always_comb
    begin
        bcdWork = '0;
        // MSB first
        for (int i = InWidth - 1; i >= 0; i--)
        begin
            // Correct every digit that would overflow on the shift
            for (int d = 0; d < Digits; d++)
            begin
                if (bcdWork[d*4 +: 4] >= 4'd5)
                begin
                    bcdWork[d*4 +: 4] = bcdWork[d*4 +: 4] + 4'd3;
                end
            end
            // Next binary bit enters at the ones digit
            bcdWork = {bcdWork[Digits*4-2:0], bin[i]};
        end
    end

    // Digit 0 is the ones digit
    // Anything past the top digit falls off the end
    assign digits = bcdWork;

endmodule

`default_nettype wire

//--- design/bcdCmdSequencer.sv
`timescale 1ns/1ps
`default_nettype none

// Command front end
// One command in, one request level out, wait for its acknowledge
module bcdCmdSequencer #(
    parameter int OperandWidth = bcdAddPkg::OperandWidth
) (
    input  wire logic                    CLK,
    input  wire logic                    rstN,
    input  wire logic                    cmdValid,
    input  wire bcdAddPkg::cmdCodeT      cmdCode,
    input  wire logic [OperandWidth-1:0] cmdData,
    input  wire logic                    initAck,
    input  wire logic                    loadAAck,
    input  wire logic                    loadBAck,
    input  wire logic                    showAAck,
    input  wire logic                    showBAck,
    input  wire logic                    addAck,
    input  wire logic                    showLsAck,
    input  wire logic                    showMsAck,
    output logic                         busy,
    output logic                         done,
    output logic [OperandWidth-1:0]      loadData,
    output logic                         initReq,
    output logic                         loadAReq,
    output logic                         loadBReq,
    output logic                         showAReq,
    output logic                         showBReq,
    output logic                         addReq,
    output logic                         showLsReq,
    output logic                         showMsReq
);

    typedef enum logic [1:0]
    {
        Idle    = 2'd0,
        Request = 2'd1,
        Finish  = 2'd2
    } stateT;

    stateT              state;
    bcdAddPkg::cmdCodeT cmdCodeQ;
    logic               accept;
    logic [7:0]         ackVec;
    logic [7:0]         reqVec;

    ////////////////////
    // Command capture
    ////////////////////

    // Not taken while a request is outstanding, so a busy strobe is lost
    assign accept = cmdValid && (state != Request);

    // Code and value held for the whole request
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmdCodeQ <= cmdCode;
            loadData <= cmdData;
        end
    end

    ////////////////////
    // FSM
    ////////////////////

    // Acks gathered in command code order
    assign ackVec = {showMsAck, showLsAck, addAck, showBAck,
                     showAAck, loadBAck, loadAAck, initAck};

    always_ff @(posedge CLK or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= Idle;
            busy  <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            case (state)
                Idle, Finish:
                begin
                    // done lasts exactly the Finish cycle
                    done <= 1'b0;
                    if (accept)
                    begin
                        state <= Request;
                        busy  <= 1'b1;
                    end
                    else
                    begin
                        state <= Idle;
                    end
                end
                Request:
                begin
                    // Only the matching ack ends the request
                    if (ackVec[cmdCodeQ])
                    begin
                        state <= Finish;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                default:
                begin
                    state <= Idle;
                    busy  <= 1'b0;
                    done  <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////
    // Request decode
    ////////////////////

    // One level per command, high only in Request
    assign reqVec = (state == Request) ? (8'd1 << cmdCodeQ) : 8'd0;

    assign initReq   = reqVec[bcdAddPkg::CmdInit];
    assign loadAReq  = reqVec[bcdAddPkg::CmdLoadA];
    assign loadBReq  = reqVec[bcdAddPkg::CmdLoadB];
    assign showAReq  = reqVec[bcdAddPkg::CmdShowA];
    assign showBReq  = reqVec[bcdAddPkg::CmdShowB];
    assign addReq    = reqVec[bcdAddPkg::CmdAdd];
    assign showLsReq = reqVec[bcdAddPkg::CmdShowLs];
    assign showMsReq = reqVec[bcdAddPkg::CmdShowMs];

    // The datapath relies on never seeing two requests at once
    assert property (@(posedge CLK) disable iff (!rstN)
        $onehot0({showMsReq, showLsReq, addReq, showBReq,
                  showAReq, loadBReq, loadAReq, initReq}));

    // Completion and busy never overlap
    assert property (@(posedge CLK) disable iff (!rstN) !(done && busy));

endmodule

`default_nettype wire

//--- design/bcdAddDatapath.sv
`timescale 1ns/1ps
`default_nettype none

// Operand and sum storage, adder, display byte
// Acts once per request, on the edge the ack rises
module bcdAddDatapath #(
    parameter int OperandWidth = bcdAddPkg::OperandWidth
) (
    input  wire logic                    CLK,
    input  wire logic                    rstN,
    input  wire logic [OperandWidth-1:0] loadData,
    input  wire logic                    initReq,
    input  wire logic                    loadAReq,
    input  wire logic                    loadBReq,
    input  wire logic                    showAReq,
    input  wire logic                    showBReq,
    input  wire logic                    addReq,
    input  wire logic                    showLsReq,
    input  wire logic                    showMsReq,
    output logic                         initAck,
    output logic                         loadAAck,
    output logic                         loadBAck,
    output logic                         showAAck,
    output logic                         showBAck,
    output logic                         addAck,
    output logic                         showLsAck,
    output logic                         showMsAck,
    output logic                         cmdError,
    output logic [7:0]                   displayData
);

    // Two digits per operand, 0 to 99
    localparam int OperandDigits = 2;

    logic [OperandWidth-1:0] opA;
    logic [OperandWidth-1:0] opB;
    logic [OperandWidth:0]   sum;
    logic [7:0]              reqVec;
    logic [7:0]              ackVec;
    logic [7:0]              actVec;
    logic                    loadTooBig;

    bcdAddPkg::bcdDigitT [OperandDigits-1:0]       opABcd;
    bcdAddPkg::bcdDigitT [OperandDigits-1:0]       opBBcd;
    bcdAddPkg::bcdDigitT [bcdAddPkg::SumDigits-1:0] sumBcd;

    ////////////////////
    // BCD views
    ////////////////////

    binToBcd #(.InWidth(OperandWidth), .Digits(OperandDigits)) uBcdA
    (
        .bin    (opA),
        .digits (opABcd)
    );

    binToBcd #(.InWidth(OperandWidth), .Digits(OperandDigits)) uBcdB
    (
        .bin    (opB),
        .digits (opBBcd)
    );

    // One extra bit for the carry out of A+B
    binToBcd #(.InWidth(OperandWidth + 1), .Digits(bcdAddPkg::SumDigits)) uBcdSum
    (
        .bin    (sum),
        .digits (sumBcd)
    );

    ////////////////////
    // Handshake
    ////////////////////

    // Same bit order as the command codes
    assign reqVec = {showMsReq, showLsReq, addReq, showBReq,
                     showAReq, loadBReq, loadAReq, initReq};

    // Request seen but not yet acked, i.e. first cycle only
    assign actVec = reqVec & ~ackVec;

    assign loadTooBig = (loadData > bcdAddPkg::OperandMax);

    always_ff @(posedge CLK or negedge rstN)
    begin
        if (!rstN)
        begin
            ackVec      <= '0;
            opA         <= '0;
            opB         <= '0;
            sum         <= '0;
            cmdError    <= 1'b0;
            displayData <= '0;
        end
        else
        begin
            // Ack follows its request one edge later, both ways
            ackVec <= reqVec;
            if (|actVec)
            begin
                // Refused loads are the only source of an error
                cmdError <= 1'b0;
                if (actVec[bcdAddPkg::CmdInit])
                begin
                    opA         <= '0;
                    opB         <= '0;
                    sum         <= '0;
                    displayData <= '0;
                end
                else if (actVec[bcdAddPkg::CmdLoadA] || actVec[bcdAddPkg::CmdLoadB])
                begin
                    if (loadTooBig)
                        cmdError <= 1'b1;
                    else if (actVec[bcdAddPkg::CmdLoadA])
                        opA <= loadData;
                    else
                        opB <= loadData;
                end
                else if (actVec[bcdAddPkg::CmdShowA])
                    displayData <= opABcd;
                else if (actVec[bcdAddPkg::CmdShowB])
                    displayData <= opBBcd;
                else if (actVec[bcdAddPkg::CmdAdd])
                    sum <= opA + opB;
                else if (actVec[bcdAddPkg::CmdShowLs])
                    displayData <= {sumBcd[1], sumBcd[0]};
                else
                    // Hundreds digit in the lower nibble
                    displayData <= {4'd0, sumBcd[2]};
            end
        end
    end

    assign initAck   = ackVec[bcdAddPkg::CmdInit];
    assign loadAAck  = ackVec[bcdAddPkg::CmdLoadA];
    assign loadBAck  = ackVec[bcdAddPkg::CmdLoadB];
    assign showAAck  = ackVec[bcdAddPkg::CmdShowA];
    assign showBAck  = ackVec[bcdAddPkg::CmdShowB];
    assign addAck    = ackVec[bcdAddPkg::CmdAdd];
    assign showLsAck = ackVec[bcdAddPkg::CmdShowLs];
    assign showMsAck = ackVec[bcdAddPkg::CmdShowMs];

    // A freshly risen ack still finds its own request held high
    assert property (@(posedge CLK) disable iff (!rstN)
        ((ackVec & ~$past(ackVec)) & ~reqVec) == 8'd0);

endmodule

`default_nettype wire

//--- design/bcdSegmentDriver.sv
`timescale 1ns/1ps
`default_nettype none

// Two seven-segment patterns from one packed BCD byte
// Bit order gfedcba, segment on when high
module bcdSegmentDriver (
    input  wire logic       CLK,
    input  wire logic       rstN,
    input  wire logic [7:0] displayData,
    output logic [6:0]      segHigh,
    output logic [6:0]      segLow
);

    // Glyph for "0", also the reset pattern
    localparam logic [6:0] GlyphZero = 7'b0111111;

    // Decimal glyphs, non-decimal codes blank
    function automatic logic [6:0] glyph(input bcdAddPkg::bcdDigitT digit);
        logic [6:0] pattern;
        case (digit)
            4'd0:    pattern = GlyphZero;
            4'd1:    pattern = 7'b0000110;
            4'd2:    pattern = 7'b1011011;
            4'd3:    pattern = 7'b1001111;
            4'd4:    pattern = 7'b1100110;
            4'd5:    pattern = 7'b1101101;
            4'd6:    pattern = 7'b1111101;
            4'd7:    pattern = 7'b0000111;
            4'd8:    pattern = 7'b1111111;
            4'd9:    pattern = 7'b1101111;
            default: pattern = 7'b0000000;
        endcase
        return pattern;
    endfunction

    ////////////////////
    // Output registers
    ////////////////////

    // One cycle behind displayData
    always_ff @(posedge CLK or negedge rstN)
    begin
        if (!rstN)
        begin
            // Display reads "00" out of reset
            segHigh <= GlyphZero;
            segLow  <= GlyphZero;
        end
        else
        begin
            // Upper nibble is the tens position
            segHigh <= glyph(displayData[7:4]);
            segLow  <= glyph(displayData[3:0]);
        end
    end

endmodule

`default_nettype wire

//--- design/bcdAdder.sv
`timescale 1ns/1ps
`default_nettype none

// Decimal adder top
// Sequencer -> datapath -> segment driver
module bcdAdder #(
    parameter int OperandWidth = bcdAddPkg::OperandWidth
) (
    input  wire logic                    CLK,
    input  wire logic                    rstN,
    input  wire logic                    cmdValid,
    input  wire bcdAddPkg::cmdCodeT      cmdCode,
    input  wire logic [OperandWidth-1:0] cmdData,
    output logic                         busy,
    output logic                         done,
    output logic                         cmdError,
    output logic [7:0]                   displayData,
    output logic [6:0]                   segHigh,
    output logic [6:0]                   segLow
);

    ////////////////////
    // Interconnect
    ////////////////////

    // Latched operand value
    logic [OperandWidth-1:0] loadData;

    // Request levels
    logic initReq;
    logic loadAReq;
    logic loadBReq;
    logic showAReq;
    logic showBReq;
    logic addReq;
    logic showLsReq;
    logic showMsReq;

    // Acknowledge levels
    logic initAck;
    logic loadAAck;
    logic loadBAck;
    logic showAAck;
    logic showBAck;
    logic addAck;
    logic showLsAck;
    logic showMsAck;

    bcdCmdSequencer #(.OperandWidth(OperandWidth)) uSequencer
    (
        .CLK       (CLK),
        .rstN      (rstN),
        .cmdValid  (cmdValid),
        .cmdCode   (cmdCode),
        .cmdData   (cmdData),
        .initAck   (initAck),
        .loadAAck  (loadAAck),
        .loadBAck  (loadBAck),
        .showAAck  (showAAck),
        .showBAck  (showBAck),
        .addAck    (addAck),
        .showLsAck (showLsAck),
        .showMsAck (showMsAck),
        .busy      (busy),
        .done      (done),
        .loadData  (loadData),
        .initReq   (initReq),
        .loadAReq  (loadAReq),
        .loadBReq  (loadBReq),
        .showAReq  (showAReq),
        .showBReq  (showBReq),
        .addReq    (addReq),
        .showLsReq (showLsReq),
        .showMsReq (showMsReq)
    );

    bcdAddDatapath #(.OperandWidth(OperandWidth)) uDatapath
    (
        .CLK         (CLK),
        .rstN        (rstN),
        .loadData    (loadData),
        .initReq     (initReq),
        .loadAReq    (loadAReq),
        .loadBReq    (loadBReq),
        .showAReq    (showAReq),
        .showBReq    (showBReq),
        .addReq      (addReq),
        .showLsReq   (showLsReq),
        .showMsReq   (showMsReq),
        .initAck     (initAck),
        .loadAAck    (loadAAck),
        .loadBAck    (loadBAck),
        .showAAck    (showAAck),
        .showBAck    (showBAck),
        .addAck      (addAck),
        .showLsAck   (showLsAck),
        .showMsAck   (showMsAck),
        .cmdError    (cmdError),
        .displayData (displayData)
    );

    // Display byte also leaves the top directly
    bcdSegmentDriver uSegments
    (
        .CLK         (CLK),
        .rstN        (rstN),
        .displayData (displayData),
        .segHigh     (segHigh),
        .segLow      (segLow)
    );

endmodule

`default_nettype wire

//--- dv/tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and power-on reset
module tbClockGen #(
    parameter int PeriodNs    = 40,
    parameter int ResetCycles = 4
) (
    output logic CLK,
    output logic rstN
);

    // Half period high, half low
    initial
    begin
        CLK = 1'b0;
        forever #(PeriodNs / 2) CLK = ~CLK;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial
    begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge CLK);
        @(negedge CLK);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/bcdAdderTb.sv
`timescale 1ns/1ps
`default_nettype none

module bcdAdderTb;

    localparam int ClockPeriodNs = 40;
    localparam int ResetCycles   = 4;
    localparam int OperandWidth  = bcdAddPkg::OperandWidth;
    localparam int RandomRounds  = 40;
    // LoadA, LoadB, Add, ShowLs, ShowMs
    localparam int CmdsPerRound  = 5;
    // Budget per command for the watchdog
    localparam int CyclesPerCmd  = 6;
    localparam int DoneTimeout   = 20;
    localparam logic [31:0] Seed = 32'd7041;

    logic                    CLK;
    logic                    rstN;
    logic                    cmdValid;
    bcdAddPkg::cmdCodeT      cmdCode;
    logic [OperandWidth-1:0] cmdData;
    logic                    busy;
    logic                    done;
    logic                    cmdError;
    logic [7:0]              displayData;
    logic [6:0]              segHigh;
    logic [6:0]              segLow;

    int   errorCount     = 0;
    int   checkCount     = 0;
    int   commandCount   = 0;
    int   doneCount      = 0;
    bit   patternsLoaded = 1'b0;
    int   patCode[$];
    int   patValue[$];
    int   patDisplay[$];
    int   patError[$];

    tbClockGen #(.PeriodNs(ClockPeriodNs), .ResetCycles(ResetCycles)) uClockGen
    (
        .CLK  (CLK),
        .rstN (rstN)
    );

    bcdAdder #(.OperandWidth(OperandWidth)) u_dut
    (
        .CLK         (CLK),
        .rstN        (rstN),
        .cmdValid    (cmdValid),
        .cmdCode     (cmdCode),
        .cmdData     (cmdData),
        .busy        (busy),
        .done        (done),
        .cmdError    (cmdError),
        .displayData (displayData),
        .segHigh     (segHigh),
        .segLow      (segLow)
    );

    ////////////////////
    // Reference models
    ////////////////////

    // Decimal glyphs gfedcba, codes above 9 blank
    function automatic logic [6:0] expectedSegments(input logic [3:0] digit);
        logic [6:0] pattern;
        case (digit)
            4'd0:    pattern = 7'b0111111;
            4'd1:    pattern = 7'b0000110;
            4'd2:    pattern = 7'b1011011;
            4'd3:    pattern = 7'b1001111;
            4'd4:    pattern = 7'b1100110;
            4'd5:    pattern = 7'b1101101;
            4'd6:    pattern = 7'b1111101;
            4'd7:    pattern = 7'b0000111;
            4'd8:    pattern = 7'b1111111;
            4'd9:    pattern = 7'b1101111;
            default: pattern = 7'b0000000;
        endcase
        return pattern;
    endfunction

    // 32-bit xorshift, shifts 13/17/5
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Every done pulse, one sample per cycle
    always @(negedge CLK)
    begin
        if (done)
        begin
            doneCount++;
        end
    end

    ////////////////////
    // Tasks
    ////////////////////

    // Pattern lines are four hex fields, comment lines fail the scan
    task automatic readPatterns();
        int    fd;
        int    n;
        int    code;
        int    value;
        int    expDisplay;
        int    expError;
        string line;
        fd = $fopen("dv/bcdAdderPatterns.txt", "r");
        if (fd == 0)
        begin
            errorCount++;
            $display("Could not open the pattern file dv/bcdAdderPatterns.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h", code, value, expDisplay, expError);
                if (n == 4)
                begin
                    patCode.push_back(code);
                    patValue.push_back(value);
                    patDisplay.push_back(expDisplay);
                    patError.push_back(expError);
                end
            end
            $fclose(fd);
        end
    endtask

    // One command, plus a stray strobe while busy that must be dropped
    task automatic runCommand(input bcdAddPkg::cmdCodeT code,
                              input logic [OperandWidth-1:0] value);
        int waitCycles;
        commandCount++;
        @(negedge CLK);
        cmdValid = 1'b1;
        cmdCode  = code;
        cmdData  = value;
        @(negedge CLK);
        cmdValid = 1'b0;
        if (!busy)
        begin
            errorCount++;
            $display("[FAIL] %0t ns: busy low after command %0d was taken", $time, commandCount);
        end
        // Request outstanding here
        @(negedge CLK);
        cmdValid = 1'b1;
        cmdCode  = bcdAddPkg::CmdInit;
        cmdData  = '0;
        @(negedge CLK);
        cmdValid   = 1'b0;
        waitCycles = 0;
        while (!done && waitCycles < DoneTimeout)
        begin
            @(negedge CLK);
            waitCycles++;
        end
        if (!done)
        begin
            errorCount++;
            $display("No done for command %0d within %0d cycles", commandCount, DoneTimeout);
        end
        else if (waitCycles != 0)
        begin
            // Done belongs three cycles after acceptance
            errorCount++;
            $display("[FAIL] %0t ns: done late by %0d cycles", $time, waitCycles);
        end
        // Single-cycle done, busy already gone
        @(negedge CLK);
        if (done || busy)
        begin
            errorCount++;
            $display("[FAIL] %0t ns: done=%0b busy=%0b one cycle after done", $time, done, busy);
        end
    endtask

    // Display byte, error flag and both glyphs
    task automatic checkResult(input logic [7:0] expDisplay, input logic expError,
                               input string what);
        checkCount++;
        if (displayData !== expDisplay)
        begin
            errorCount++;
            $display("[FAIL] %0t ns: %s displayData expected %02h got %02h",
                     $time, what, expDisplay, displayData);
        end
        if (cmdError !== expError)
        begin
            errorCount++;
            $display("[FAIL] %0t ns: %s cmdError expected %0b got %0b",
                     $time, what, expError, cmdError);
        end
        if (segHigh !== expectedSegments(expDisplay[7:4]) ||
            segLow !== expectedSegments(expDisplay[3:0]))
        begin
            errorCount++;
            $display("[FAIL] %0t ns: %s segments expected %07b %07b got %07b %07b",
                     $time, what, expectedSegments(expDisplay[7:4]),
                     expectedSegments(expDisplay[3:0]), segHigh, segLow);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        logic [31:0] rngState;
        logic [7:0]  lastDisplay;
        logic [7:0]  expLs;
        logic [7:0]  expMs;
        int          valA;
        int          valB;
        int          sumVal;
        cmdValid    = 1'b0;
        cmdCode     = bcdAddPkg::CmdInit;
        cmdData     = '0;
        rngState    = Seed;
        lastDisplay = 8'h00;
        wait (rstN === 1'b1);
        @(negedge CLK);
        checkResult(8'h00, 1'b0, "after reset");
        if (busy || done)
        begin
            errorCount++;
            $display("[FAIL] %0t ns: busy=%0b done=%0b after reset", $time, busy, done);
        end
        readPatterns();
        patternsLoaded = 1'b1;

        // Directed patterns from the file
        for (int i = 0; i < patCode.size(); i++)
        begin
            runCommand(bcdAddPkg::cmdCodeT'(patCode[i]), OperandWidth'(patValue[i]));
            checkResult(8'(patDisplay[i]), patError[i] != 0, $sformatf("pattern %0d", i));
            lastDisplay = 8'(patDisplay[i]);
        end

        // Random legal operands, sum digits worked out here
        for (int round = 0; round < RandomRounds; round++)
        begin
            rngState = xorshift32(rngState);
            valA     = int'(rngState % (bcdAddPkg::OperandMax + 1));
            rngState = xorshift32(rngState);
            valB     = int'(rngState % (bcdAddPkg::OperandMax + 1));
            sumVal   = valA + valB;
            expLs    = {4'((sumVal / 10) % 10), 4'(sumVal % 10)};
            expMs    = {4'd0, 4'(sumVal / 100)};
            runCommand(bcdAddPkg::CmdLoadA, OperandWidth'(valA));
            checkResult(lastDisplay, 1'b0, $sformatf("round %0d loadA", round));
            runCommand(bcdAddPkg::CmdLoadB, OperandWidth'(valB));
            checkResult(lastDisplay, 1'b0, $sformatf("round %0d loadB", round));
            runCommand(bcdAddPkg::CmdAdd, '0);
            checkResult(lastDisplay, 1'b0, $sformatf("round %0d add", round));
            runCommand(bcdAddPkg::CmdShowLs, '0);
            checkResult(expLs, 1'b0, $sformatf("round %0d showLs", round));
            runCommand(bcdAddPkg::CmdShowMs, '0);
            checkResult(expMs, 1'b0, $sformatf("round %0d showMs", round));
            lastDisplay = expMs;
        end

        // Dropped strobes must not have made extra done pulses
        repeat (4) @(negedge CLK);
        if (doneCount != commandCount)
        begin
            errorCount++;
            $display("[FAIL] %0t ns: %0d done pulses for %0d commands",
                     $time, doneCount, commandCount);
        end

        $display("Commands: %0d, checks: %0d, errors: %0d", commandCount, checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog, sized once the pattern count is known
    initial
    begin
        longint limitNs;
        wait (patternsLoaded);
        limitNs = (longint'(patCode.size()) + RandomRounds * CmdsPerRound)
                  * CyclesPerCmd * ClockPeriodNs + (ResetCycles + 20) * ClockPeriodNs;
        #(limitNs);
        $display("Timeout: the run did not finish within %0d ns", limitNs);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/bcdAdderPatterns.txt
# Columns (hex): command code, operand value, expected displayData, expected cmdError
# Codes: 0 init, 1 loadA, 2 loadB, 3 showA, 4 showB, 5 add, 6 showLs, 7 showMs
0 00 00 0
1 2f 00 0
3 00 47 0
2 08 47 0
4 00 08 0
1 63 08 0
2 63 08 0
5 00 08 0
6 00 98 0
7 00 01 0
1 0c 01 0
2 1e 01 0
5 00 01 0
6 00 42 0
7 00 00 0
1 78 00 1
3 00 12 0
2 64 12 1
4 00 30 0
0 00 00 0
3 00 00 0

//--- bcdAdder.f
design/bcdAddPkg.sv
design/binToBcd.sv
design/bcdCmdSequencer.sv
design/bcdAddDatapath.sv
design/bcdSegmentDriver.sv
design/bcdAdder.sv
dv/tbClockGen.sv
dv/bcdAdderTb.sv

//--- Bender.yml
package:
  name: bcdAdder

sources:
  - design/bcdAddPkg.sv
  - design/binToBcd.sv
  - design/bcdCmdSequencer.sv
  - design/bcdAddDatapath.sv
  - design/bcdSegmentDriver.sv
  - design/bcdAdder.sv
  - target: simulation
    files:
      - dv/tbClockGen.sv
      - dv/bcdAdderTb.sv
